// File: include/status_panel_macros.svh
`ifndef STATUS_PANEL_MACROS_SVH
`define STATUS_PANEL_MACROS_SVH

// width of one configuration word, shared by both register views
`define STATUS_CFG_WIDTH 16

// register map, a single address bit selects the register
`define STATUS_CFG_ADDR_DIM 1'b0
`define STATUS_CFG_ADDR_HOLD 1'b1

// dimmer defaults give a short lit slot out of a 51 clock frame
`define STATUS_DIM_PERIOD_RESET 8'd50
`define STATUS_DIM_DUTY_RESET 8'd1

// flash hold time in clocks after reset
`define STATUS_HOLD_RESET 16'd1000

`endif

// File: design/status_panel_pkg.sv
`include "status_panel_macros.svh"

package status_panel_pkg;

    // one rgb led, every channel is a simple on/off level
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } led_rgb_t;

    // level status reported by the controller
    typedef struct packed {
        logic init_done;
        logic idle;
        logic wait_cmd;
    } ctrl_status_t;

    // dimmer frame length and lit part of the frame
    typedef struct packed {
        logic [7:0] period;
        logic [7:0] duty;
    } dim_cfg_t;

    // a configuration write carries either dimmer settings or a hold count,
    // the register address tells which view applies
    typedef union packed {
        dim_cfg_t                      dim;
        logic [`STATUS_CFG_WIDTH-1:0]  hold;
    } cfg_word_u;

endpackage

// File: design/status_config_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "status_panel_macros.svh"

module status_config_regs
    import status_panel_pkg::*;
(
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_cfg_write,
    input  logic                          i_cfg_addr,
    input  cfg_word_u                     i_cfg_data,
    output dim_cfg_t                      o_dim_cfg,
    output logic [`STATUS_CFG_WIDTH-1:0]  o_hold_cycles
);

    dim_cfg_t                      dim_reg;
    logic [`STATUS_CFG_WIDTH-1:0]  hold_reg;
    logic                          write_dim;
    logic                          write_hold;

    assign write_dim  = i_cfg_write && (i_cfg_addr == `STATUS_CFG_ADDR_DIM);
    assign write_hold = i_cfg_write && (i_cfg_addr == `STATUS_CFG_ADDR_HOLD);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            dim_reg.period <= `STATUS_DIM_PERIOD_RESET;
            dim_reg.duty   <= `STATUS_DIM_DUTY_RESET;
            hold_reg       <= `STATUS_HOLD_RESET;
        end else begin
            if (write_dim) begin
                dim_reg <= i_cfg_data.dim; // period and duty land together
            end
            if (write_hold) begin
                hold_reg <= i_cfg_data.hold;
            end
        end
    end

    assign o_dim_cfg     = dim_reg;
    assign o_hold_cycles = hold_reg;

    // the hold setting only moves right after a hold write or a reset
    a_hold_only_on_write: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !$stable(o_hold_cycles) |-> ($past(write_hold) || $past(i_reset))
    ) else $error("hold register changed without a write");

endmodule

`default_nettype wire

// File: design/led_dimmer.sv
`timescale 1ns/1ps
`default_nettype none

module led_dimmer
    import status_panel_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_reset,
    input  dim_cfg_t  i_dim_cfg,
    output logic      o_dim_on
);

    logic [7:0] dim_count;
    logic       frame_end;

    // >= also catches a count left above a freshly shortened period
    assign frame_end = (dim_count >= i_dim_cfg.period);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            dim_count <= '0;
            o_dim_on  <= 1'b0;
        end else begin
            dim_count <= frame_end ? 8'd0 : dim_count + 8'd1;
            // duty 0 never lights, duty above the period always lights
            o_dim_on  <= (dim_count < i_dim_cfg.duty);
        end
    end

    // a zero duty must turn the gate off by the next edge
    a_zero_duty_dark: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (i_dim_cfg.duty == 8'd0) |=> !o_dim_on
    ) else $error("dim gate high after zero duty");

endmodule

`default_nettype wire

// File: design/status_led_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "status_panel_macros.svh"

module status_led_unit
    import status_panel_pkg::*;
(
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  ctrl_status_t                  i_status,
    input  logic                          i_error,
    input  logic                          i_success,
    input  logic                          i_dim_on,
    input  logic [`STATUS_CFG_WIDTH-1:0]  i_hold_cycles,
    output led_rgb_t                      o_led0,
    output led_rgb_t                      o_led1
);

    logic                          error_flag;
    logic                          success_flag;
    logic                          flash_active;
    logic                          hold_done;
    logic [`STATUS_CFG_WIDTH-1:0]  hold_count;
    logic [`STATUS_CFG_WIDTH-1:0]  hold_limit;

    // led0 follows the controller state directly
    always_comb begin
        o_led0 = '0;
        if (!i_status.init_done) begin
            o_led0.r = i_dim_on;
        end else if (i_status.idle) begin
            o_led0.g = i_dim_on;
            o_led0.r = i_status.wait_cmd & i_dim_on; // yellow while waiting
        end else begin
            o_led0.b = i_dim_on; // busy
        end
    end

    assign flash_active = error_flag || success_flag;
    assign hold_done    = (hold_count >= hold_limit);

    // limit is captured when the flash starts, so a mid flash write waits
    always_ff @(posedge i_clock) begin
        if (!flash_active) begin
            hold_limit <= i_hold_cycles;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            error_flag   <= 1'b0;
            success_flag <= 1'b0;
            hold_count   <= '0;
        end else if (flash_active) begin
            if (hold_done) begin
                error_flag   <= 1'b0;
                success_flag <= 1'b0;
                hold_count   <= '0;
            end else begin
                hold_count <= hold_count + 1'b1; // new events are ignored here
            end
        end else begin
            error_flag   <= i_error;
            success_flag <= i_success;
            hold_count   <= '0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_led1 <= '0;
        end else begin
            o_led1.r <= error_flag & i_dim_on;
            o_led1.g <= 1'b0; // green of led1 is unused
            o_led1.b <= success_flag & i_dim_on;
        end
    end

    a_led1_green_dark: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !o_led1.g
    ) else $error("led1 green lit");

    // the counter must stop at the captured limit and never run past it
    a_hold_in_range: assert property (
        @(posedge i_clock) disable iff (i_reset)
        flash_active |-> (hold_count <= hold_limit)
    ) else $error("hold counter ran past its limit");

endmodule

`default_nettype wire

// File: design/status_panel_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "status_panel_macros.svh"

module status_panel_top
    import status_panel_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_reset,
    input  ctrl_status_t  i_status,
    input  logic          i_error,
    input  logic          i_success,
    input  logic          i_cfg_write,
    input  logic          i_cfg_addr,
    input  cfg_word_u     i_cfg_data,
    output led_rgb_t      o_led0,
    output led_rgb_t      o_led1
);

    dim_cfg_t                      dim_cfg;
    logic [`STATUS_CFG_WIDTH-1:0]  hold_cycles;
    logic                          dim_on;

    status_config_regs u_config_regs (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_cfg_write   (i_cfg_write),
        .i_cfg_addr    (i_cfg_addr),
        .i_cfg_data    (i_cfg_data),
        .o_dim_cfg     (dim_cfg),
        .o_hold_cycles (hold_cycles)
    );

    led_dimmer u_dimmer (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_dim_cfg (dim_cfg),
        .o_dim_on  (dim_on)
    );

    status_led_unit u_led_unit (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_status      (i_status),
        .i_error       (i_error),
        .i_success     (i_success),
        .i_dim_on      (dim_on),
        .i_hold_cycles (hold_cycles),
        .o_led0        (o_led0),
        .o_led1        (o_led1)
    );

endmodule

`default_nettype wire

// File: verification/status_panel_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "status_panel_macros.svh"

module status_panel_tb
    import status_panel_pkg::*;
();

    localparam int MAX_CYCLES  = 4000;
    localparam int DRIVE_DELAY = 10;

    logic          i_clock;
    logic          i_reset;
    ctrl_status_t  i_status;
    logic          i_error;
    logic          i_success;
    logic          i_cfg_write;
    logic          i_cfg_addr;
    cfg_word_u     i_cfg_data;
    led_rgb_t      o_led0;
    led_rgb_t      o_led1;

    logic [31:0]   lfsr_state;
    int            cycle_count = 0;

    status_panel_top uut (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_status    (i_status),
        .i_error     (i_error),
        .i_success   (i_success),
        .i_cfg_write (i_cfg_write),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_data  (i_cfg_data),
        .o_led0      (o_led0),
        .o_led1      (o_led1)
    );

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    always @(posedge i_clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            report_failure("timeout, the tests did not finish within the cycle limit");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            value      = {value[14:0], lfsr_state[0]};
        end
    endtask

    // expected led0 colour written from the state table
    function automatic led_rgb_t led0_rule(input ctrl_status_t s, input logic lit);
        led_rgb_t colour;
        colour.r = lit & (!s.init_done | (s.idle & s.wait_cmd));
        colour.g = lit & s.init_done & s.idle;
        colour.b = lit & s.init_done & !s.idle;
        return colour;
    endfunction

    task automatic check_led(input string name, input led_rgb_t got, input led_rgb_t expected);
        if (got !== expected) begin
            report_failure($sformatf("** Error: %s got 0x%h expected 0x%h",
                                     name, got, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            report_failure($sformatf("** Error: %s got 0x%h expected 0x%h",
                                     name, got, expected));
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            report_failure($sformatf("** Error: %s got 0x%h expected 0x%h",
                                     name, got, expected));
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clock);
        #DRIVE_DELAY;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) next_cycle();
    endtask

    task automatic write_cfg(input logic addr, input cfg_word_u data);
        i_cfg_write = 1'b1;
        i_cfg_addr  = addr;
        i_cfg_data  = data;
        next_cycle();
        i_cfg_write = 1'b0;
    endtask

    task automatic write_dim(input logic [7:0] period, input logic [7:0] duty);
        cfg_word_u word;
        word.dim.period = period;
        word.dim.duty   = duty;
        write_cfg(`STATUS_CFG_ADDR_DIM, word);
    endtask

    task automatic write_hold(input logic [15:0] hold);
        cfg_word_u word;
        word.hold = hold;
        write_cfg(`STATUS_CFG_ADDR_HOLD, word);
    endtask

    task automatic random_hold(output logic [15:0] hold);
        logic [15:0] bits;
        take_bits(6, bits);
        hold = (bits % 16'd62) + 16'd2; // keeps the flash long enough for a stray pulse
    endtask

    task automatic test_reset_state();
        repeat (8) begin
            next_cycle();
            check_led("o_led1", o_led1, '0);
        end
    endtask

    task automatic test_dimming_gate();
        int         lit_count;
        logic [1:0] prev_lit;
        write_dim(8'd10, 8'd0);
        idle_cycles(2);
        for (int k = 0; k < 8; k++) begin
            i_status = k[2:0];
            repeat (4) begin
                next_cycle();
                check_led("o_led0", o_led0, '0);
            end
        end
        write_dim(8'd5, 8'd6);
        i_status = 3'b000;
        idle_cycles(2);
        repeat (20) begin
            next_cycle();
            check_led("o_led0", o_led0, led0_rule(i_status, 1'b1));
        end
        write_dim(8'd3, 8'd2);
        idle_cycles(4);
        lit_count = 0;
        prev_lit  = '0;
        for (int c = 0; c < 40; c++) begin
            next_cycle();
            if (c >= 2) begin
                check_bit("o_led0.r", o_led0.r, !prev_lit[1]); // two lit, then two dark
            end
            prev_lit = {prev_lit[0], o_led0.r};
            if (o_led0.r) begin
                lit_count++;
            end
        end
        check_count("o_led0.r lit cycles", lit_count, 20);
    endtask

    task automatic test_state_colouring();
        logic [15:0]  bits;
        ctrl_status_t s;
        write_dim(8'd3, 8'd255);
        idle_cycles(2);
        repeat (16) begin
            take_bits(3, bits);
            s        = bits[2:0];
            i_status = s;
            #1;
            check_led("o_led0", o_led0, led0_rule(s, 1'b1));
            next_cycle();
            check_led("o_led0", o_led0, led0_rule(s, 1'b1));
        end
        i_status = 3'b110;
    endtask

    task automatic run_flash(input logic err, input logic suc, input logic [15:0] hold,
                             input logic stray_success, input logic mid_write,
                             input logic [15:0] mid_hold);
        led_rgb_t expected;
        expected   = '0;
        expected.r = err;
        expected.b = suc;
        i_error    = err;
        i_success  = suc;
        next_cycle();
        i_error    = 1'b0;
        i_success  = 1'b0;
        check_led("o_led1", o_led1, '0); // flag set, led1 one edge behind
        for (int i = 0; i <= int'(hold); i++) begin
            next_cycle();
            i_success   = 1'b0;
            i_cfg_write = 1'b0;
            check_led("o_led1", o_led1, expected);
            if (i == 0 && stray_success) begin
                i_success = 1'b1;
            end
            if (i == 0 && mid_write) begin
                i_cfg_write     = 1'b1;
                i_cfg_addr      = `STATUS_CFG_ADDR_HOLD;
                i_cfg_data.hold = mid_hold;
            end
        end
        repeat (4) begin
            next_cycle();
            check_led("o_led1", o_led1, '0);
        end
    endtask

    task automatic test_error_flash();
        logic [15:0] hold;
        random_hold(hold);
        write_hold(hold);
        idle_cycles(1);
        run_flash(1'b1, 1'b0, hold, 1'b1, 1'b0, 16'd0);
    endtask

    task automatic test_success_flash();
        logic [15:0] hold;
        logic [15:0] next_hold;
        random_hold(hold);
        write_hold(hold);
        idle_cycles(1);
        run_flash(1'b0, 1'b1, hold, 1'b0, 1'b0, 16'd0);
        run_flash(1'b1, 1'b1, hold, 1'b0, 1'b0, 16'd0);
        random_hold(next_hold);
        if (next_hold == hold) begin
            next_hold = hold ^ 16'd1; // the two flash lengths must differ
        end
        run_flash(1'b0, 1'b1, hold, 1'b0, 1'b1, next_hold);
        run_flash(1'b1, 1'b0, next_hold, 1'b0, 1'b0, 16'd0);
    endtask

    initial begin
        lfsr_state  = 32'he5c2036c;
        i_reset     = 1'b1;
        i_status    = '0;
        i_error     = 1'b0;
        i_success   = 1'b0;
        i_cfg_write = 1'b0;
        i_cfg_addr  = 1'b0;
        i_cfg_data  = '0;
        repeat (4) @(posedge i_clock);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        test_reset_state();
        test_dimming_gate();
        test_state_colouring();
        test_error_flash();
        test_success_flash();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
design/status_panel_pkg.sv
design/status_config_regs.sv
design/led_dimmer.sv
design/status_led_unit.sv
design/status_panel_top.sv
verification/status_panel_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f sources.f \
    --top-module status_panel_tb -Mdir obj_dir -o status_panel_sim

# the log decides the result, so a non-zero exit of the run is caught here
./obj_dir/status_panel_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
